//--- logic/isaPkg.sv
package isaPkg;

	typedef logic [17:0] instT;
	typedef logic [3:0]  regSelT;
	typedef logic [3:0]  aluOpT;
	typedef logic [3:0]  memOpT;
	typedef logic [3:0]  specOpT;

	////////////////////////////////////////////////////////////////////////////
	// Opcode encodings
	////////////////////////////////////////////////////////////////////////////

	// ALU operations, bits 7..4 in register form, bits 15..12 in immediate form
	localparam aluOpT ALU_ADD  = 4'd1;
	localparam aluOpT ALU_SUB  = 4'd2;
	localparam aluOpT ALU_AND  = 4'd3;
	localparam aluOpT ALU_OR   = 4'd4;
	localparam aluOpT ALU_XOR  = 4'd5;
	localparam aluOpT ALU_NOT  = 4'd6;
	localparam aluOpT ALU_LSH  = 4'd7;
	localparam aluOpT ALU_RSH  = 4'd8;
	localparam aluOpT ALU_ARSH = 4'd9;
	localparam aluOpT ALU_CMP  = 4'd10;
	localparam aluOpT ALU_CMPR = 4'd11;
	localparam aluOpT ALU_MUL  = 4'd12;
	localparam aluOpT ALU_FMUL = 4'd13;
	localparam aluOpT ALU_MOVR = 4'd14;

	// Register/memory moves, no immediate form
	localparam memOpT MEM_MOVMR = 4'd1;
	localparam memOpT MEM_MOVRM = 4'd2;

	// Special group, opcode in bits 17..14
	localparam specOpT OP_CALL   = 4'd4;
	localparam specOpT OP_MOVMRI = 4'd5;
	localparam specOpT OP_MOVRMI = 4'd6;
	localparam specOpT OP_RET    = 4'd7;
	localparam specOpT OP_JL     = 4'd8;
	localparam specOpT OP_JLE    = 4'd9;
	localparam specOpT OP_JNE    = 4'd10;
	localparam specOpT OP_JE     = 4'd11;
	localparam specOpT OP_POP    = 4'd12;
	localparam specOpT OP_PUSH   = 4'd13;
	localparam specOpT OP_PUSHI  = 4'd14;

	// Six-bit opcodes in bits 17..12
	localparam logic [5:0] INCR_OP = 6'd60;
	localparam logic [5:0] DECR_OP = 6'd61;

	// Register file layout
	localparam regSelT PORT2_LOW = 4'd12;
	localparam regSelT SP_REG    = 4'd13;
	localparam regSelT PC_REG    = 4'd15;

	typedef struct packed {
		logic low;
		logic negative;
		logic zero;
	} flagsT;

	typedef enum logic [2:0] {
		NORMAL,
		MEMORY,
		IMMEDIATE,
		ADDR14,
		STACK,
		INCDEC,
		ILLEGAL
	} instClassT;

	// Stage 1 to stage 2 payload
	typedef struct packed {
		instClassT instClass;
		instT      inst;
		flagsT     flags;
		logic      valid;
	} classT;

endpackage

//--- logic/ctrlPkg.sv
package ctrlPkg;

	typedef logic [15:0] wordT;

	////////////////////////////////////////////////////////////////////////////
	// Datapath bus enables
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic immSrc;
		logic regSrc;
		logic aluToPort1;
		logic aluToPort2;
		logic immToPort1;
		logic immToPort2;
		logic regToPort1;
		logic regToPort2;
		logic regAddr;
		logic immAddr;
		logic storeData;
		logic memToPort1;
		logic memToPort2;
		logic retPc;
		logic branchPc;
		logic pcIncr;
		logic incDecToPort1;
		logic incDecToPort2;
		logic decrement;
		logic increment;
	} busCtrlT;

	// Full decoded control word
	typedef struct packed {
		isaPkg::aluOpT  aluOp;
		logic           writeEn1;
		logic           writeEn2;
		isaPkg::regSelT destSel;
		isaPkg::regSelT destSel2;
		isaPkg::regSelT srcSel;
		logic           flagWrite;
		logic           memWrite;
		logic           memRead;
		wordT           immediate;
		wordT           addr;
		busCtrlT        bus;
		logic           illegal;
	} ctrlWordT;

endpackage

//--- logic/instClassify.sv
`timescale 1ns/1ps

module instClassify (
	input  logic          clk,
	input  logic          rst,
	input  logic          instValid,
	input  isaPkg::instT  inst,
	input  isaPkg::flagsT flags,
	output isaPkg::classT classOut
);

	import isaPkg::*;

	instClassT nextClass;

	logic      validQ;
	instClassT classQ;
	instT      instQ;
	flagsT     flagsQ;

	////////////////////////////////////////////////////////////////////////////
	// Top level decode
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (inst[17:16])
			2'b00: begin
				// Normal group, split on bits 15..12
				if (inst[15:12] == 4'd0) begin
					nextClass = NORMAL;
				end else if (inst[15:12] == 4'd1) begin
					nextClass = MEMORY;
				end else begin
					nextClass = IMMEDIATE;
				end
			end
			2'b01, 2'b10: begin
				nextClass = ADDR14;
			end
			default: begin
				// Top quarter holds the stack ops and the 1111xx group
				if (inst[17:12] == INCR_OP || inst[17:12] == DECR_OP) begin
					nextClass = INCDEC;
				end else if (specOpT'(inst[17:14]) == OP_POP ||
					specOpT'(inst[17:14]) == OP_PUSH ||
					specOpT'(inst[17:14]) == OP_PUSHI) begin
					nextClass = STACK;
				end else begin
					nextClass = ILLEGAL;
				end
			end
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Pipeline register into stage 2
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			validQ <= 1'b0;
		end else begin
			validQ <= instValid;
		end
	end

	// Payload only moves on a strobe
	always_ff @(posedge clk) begin
		if (instValid) begin
			classQ <= nextClass;
			instQ  <= inst;
			flagsQ <= flags;
		end
	end

	assign classOut = '{
		instClass: classQ,
		inst:      instQ,
		flags:     flagsQ,
		valid:     validQ
	};

	// Every encoding of the normal group is a legal class
	normalNeverIllegal: assert property (@(posedge clk) disable iff (rst)
		validQ && instQ[17:16] == 2'b00 |-> classQ != ILLEGAL);

endmodule

//--- logic/ctrlGen.sv
`timescale 1ns/1ps

module ctrlGen (
	input  logic              clk,
	input  logic              rst,
	input  isaPkg::classT     classIn,
	output logic              ctrlValid,
	output ctrlPkg::ctrlWordT ctrl
);

	import isaPkg::*;
	import ctrlPkg::*;

	ctrlWordT nextCtrl;

	// Registers 12 and 13 sit behind the second write port
	function automatic logic isPort2(input regSelT r);
		return (r == PORT2_LOW) || (r == SP_REG);
	endfunction

	function automatic logic jumpTaken(input specOpT op, input flagsT f);
		case (op)
			OP_JL:   return f.low | f.negative;
			OP_JLE:  return f.low | f.negative | f.zero;
			OP_JNE:  return ~f.zero;
			OP_JE:   return f.zero;
			default: return 1'b0;
		endcase
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Per-class control rules
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		instT     ir;
		regSelT   dest;
		aluOpT    op;
		specOpT   spec;
		logic     port2;
		logic     bad;
		ctrlWordT w;

		ir    = classIn.inst;
		dest  = ir[11:8];
		port2 = isPort2(dest);
		spec  = ir[17:14];
		op    = (classIn.instClass == IMMEDIATE) ? ir[15:12] : ir[7:4];
		bad   = 1'b0;
		w     = '0;

		case (classIn.instClass)
			NORMAL, IMMEDIATE: begin
				w.aluOp       = op;
				w.destSel     = dest;
				w.destSel2    = dest;
				w.bus.pcIncr  = 1'b1;
				if (classIn.instClass == NORMAL) begin
					w.srcSel     = ir[3:0];
					w.bus.regSrc = 1'b1;
				end else begin
					// Immediate form operates on dest in place
					w.srcSel     = dest;
					w.immediate  = {8'd0, ir[7:0]};
					w.bus.immSrc = 1'b1;
				end
				case (op)
					ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
					ALU_NOT, ALU_LSH, ALU_RSH, ALU_ARSH: begin
						w.flagWrite      = 1'b1;
						w.writeEn1       = ~port2;
						w.writeEn2       = port2;
						w.bus.aluToPort1 = ~port2;
						w.bus.aluToPort2 = port2;
					end
					ALU_CMP, ALU_CMPR: begin
						// Flags only, no writeback
						w.flagWrite = 1'b1;
					end
					ALU_MOVR: begin
						w.writeEn1 = ~port2;
						w.writeEn2 = port2;
						if (classIn.instClass == NORMAL) begin
							w.bus.regToPort1 = ~port2;
							w.bus.regToPort2 = port2;
						end else begin
							w.bus.immToPort1 = ~port2;
							w.bus.immToPort2 = port2;
						end
					end
					ALU_MUL, ALU_FMUL: bad = 1'b1;
					default:           bad = 1'b1;
				endcase
			end
			MEMORY: begin
				w.aluOp       = ir[7:4];
				w.destSel     = dest;
				w.destSel2    = dest;
				w.srcSel      = ir[3:0];
				w.bus.regSrc  = 1'b1;
				w.bus.pcIncr  = 1'b1;
				case (memOpT'(ir[7:4]))
					MEM_MOVMR: begin
						w.memRead        = 1'b1;
						w.bus.regAddr    = 1'b1;
						w.writeEn1       = ~port2;
						w.writeEn2       = port2;
						w.bus.memToPort1 = ~port2;
						w.bus.memToPort2 = port2;
					end
					MEM_MOVRM: begin
						w.memWrite      = 1'b1;
						w.bus.regAddr   = 1'b1;
						w.bus.storeData = 1'b1;
					end
					default: bad = 1'b1;
				endcase
			end
			ADDR14: begin
				w.addr        = {2'b00, ir[13:0]};
				w.destSel     = PC_REG;
				w.bus.regSrc  = 1'b1;
				w.bus.immAddr = 1'b1;
				case (spec)
					OP_CALL: begin
						w.memWrite       = 1'b1;
						w.bus.memToPort1 = 1'b1;
						w.bus.pcIncr     = 1'b1;
					end
					OP_MOVMRI: begin
						w.memRead        = 1'b1;
						w.writeEn1       = 1'b1;
						w.bus.memToPort1 = 1'b1;
						w.bus.pcIncr     = 1'b1;
					end
					OP_MOVRMI: begin
						w.memWrite      = 1'b1;
						w.bus.storeData = 1'b1;
						w.bus.pcIncr    = 1'b1;
					end
					OP_RET: begin
						w.memRead   = 1'b1;
						w.bus.retPc = 1'b1;
					end
					default: begin
						// Conditional jumps
						w.bus.branchPc = jumpTaken(spec, classIn.flags);
						w.bus.pcIncr   = ~jumpTaken(spec, classIn.flags);
					end
				endcase
			end
			STACK: begin
				w.srcSel        = SP_REG;
				w.destSel2      = SP_REG;
				w.bus.regAddr   = 1'b1;
				w.bus.storeData = 1'b1;
				w.bus.pcIncr    = 1'b1;
				if (spec == OP_POP) begin
					w.destSel = ir[13:10];
					// Popping into 12 or 13 would clobber the stack pointer
					if (!isPort2(ir[13:10])) begin
						w.writeEn1          = 1'b1;
						w.writeEn2          = 1'b1;
						w.memRead           = 1'b1;
						w.bus.regSrc        = 1'b1;
						w.bus.incDecToPort2 = 1'b1;
						w.bus.decrement     = 1'b1;
					end
				end else begin
					w.memWrite          = 1'b1;
					w.writeEn2          = 1'b1;
					w.bus.incDecToPort2 = 1'b1;
					w.bus.increment     = 1'b1;
					if (spec == OP_PUSHI) begin
						w.bus.immSrc = 1'b1;
					end else begin
						w.destSel    = ir[13:10];
						w.bus.regSrc = 1'b1;
					end
				end
			end
			INCDEC: begin
				w.srcSel            = dest;
				w.destSel           = dest;
				w.destSel2          = dest;
				w.bus.pcIncr        = 1'b1;
				w.writeEn1          = ~port2;
				w.writeEn2          = port2;
				w.bus.incDecToPort1 = ~port2;
				w.bus.incDecToPort2 = port2;
				if (ir[17:12] == INCR_OP) begin
					w.bus.increment = 1'b1;
				end else begin
					w.bus.decrement = 1'b1;
				end
			end
			default: bad = 1'b1;
		endcase

		// Illegal words carry nothing but the flag
		if (bad) begin
			w         = '0;
			w.illegal = 1'b1;
		end
		nextCtrl = w;
	end

	////////////////////////////////////////////////////////////////////////////
	// Output register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			ctrlValid <= 1'b0;
			ctrl      <= '0;
		end else begin
			ctrlValid <= classIn.valid;
			if (classIn.valid) begin
				ctrl <= nextCtrl;
			end else begin
				ctrl <= '0;
			end
		end
	end

	memExclusive: assert property (@(posedge clk) disable iff (rst)
		!(ctrl.memRead && ctrl.memWrite));

	pcSourceOne: assert property (@(posedge clk) disable iff (rst)
		ctrlValid && !ctrl.illegal |->
		$onehot({ctrl.bus.pcIncr, ctrl.bus.branchPc, ctrl.bus.retPc}));

	port1Target: assert property (@(posedge clk) disable iff (rst)
		ctrl.writeEn1 |-> !isPort2(ctrl.destSel));

endmodule

//--- logic/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
	input  logic              clk,
	input  logic              rst,
	input  logic              instValid,
	input  isaPkg::instT      inst,
	input  isaPkg::flagsT     flags,
	output logic              ctrlValid,
	output ctrlPkg::ctrlWordT ctrl
);

	import isaPkg::*;

	// Classified instruction between the stages
	classT classBus;

	instClassify classify_i (
		.clk       (clk),
		.rst       (rst),
		.instValid (instValid),
		.inst      (inst),
		.flags     (flags),
		.classOut  (classBus)
	);

	ctrlGen gen_i (
		.clk       (clk),
		.rst       (rst),
		.classIn   (classBus),
		.ctrlValid (ctrlValid),
		.ctrl      (ctrl)
	);

endmodule

//--- sim/controlUnitTb.sv
`timescale 1ns/1ps

module controlUnitTb;

	import isaPkg::*;
	import ctrlPkg::*;

	// Run length budget of about four cycles per strobe plus slack
	localparam int DIRECTED_STROBES  = 300;
	localparam int STREAM_LEN        = 40;
	localparam int CYCLES_PER_STROBE = 4;
	localparam int TIMEOUT_CYCLES    = (DIRECTED_STROBES + STREAM_LEN) * CYCLES_PER_STROBE + 640;

	logic     clk = 1'b0;
	logic     rst;
	logic     instValid;
	instT     inst;
	flagsT    flags;
	logic     ctrlValid;
	ctrlWordT ctrl;

	int          cycleCount = 0;
	int          errorCount = 0;
	int          checkCount = 0;
	int          testCount = 0;
	int          failedTests = 0;
	int          testStartErrors = 0;
	logic [31:0] lcgState = 32'h6f705f69;
	ctrlWordT    expStream [STREAM_LEN];
	instT        streamInst [STREAM_LEN];

	controlUnit dut_i (
		.clk       (clk),
		.rst       (rst),
		.instValid (instValid),
		.inst      (inst),
		.flags     (flags),
		.ctrlValid (ctrlValid),
		.ctrl      (ctrl)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run went past %0d cycles without finishing", TIMEOUT_CYCLES);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] lcgNext();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Instruction builders
	////////////////////////////////////////////////////////////////////////////

	function automatic instT regForm(input aluOpT op, input regSelT d, input regSelT s);
		return {6'd0, d, op, s};
	endfunction

	function automatic instT immForm(input aluOpT op, input regSelT d, input logic [7:0] v);
		return {2'b00, op, d, v};
	endfunction

	function automatic instT memForm(input memOpT op, input regSelT d, input regSelT s);
		return {2'b00, 4'd1, d, op, s};
	endfunction

	function automatic instT addrForm(input specOpT s, input logic [13:0] a);
		return {s, a};
	endfunction

	function automatic instT stackForm(input specOpT s, input regSelT rg,
		input logic [9:0] rest);
		return {s, rg, rest};
	endfunction

	function automatic instT incDecForm(input logic [5:0] op6, input regSelT d,
		input logic [7:0] lo);
		return {op6, d, lo};
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Reference model of the decode rules
	////////////////////////////////////////////////////////////////////////////

	function automatic ctrlWordT expectCtrl(input instT i, input flagsT f);
		ctrlWordT e;
		regSelT   d;
		aluOpT    op;
		specOpT   spec;
		logic     p2;
		logic     imm;
		logic     taken;
		logic     bad;

		e     = '0;
		d     = i[11:8];
		p2    = (d == 4'd12) || (d == 4'd13);
		spec  = i[17:14];
		bad   = 1'b0;
		taken = 1'b0;
		if (i[17:16] == 2'b00 && i[15:12] != 4'd1) begin
			// Register or immediate ALU form
			imm       = (i[15:12] != 4'd0);
			op        = imm ? i[15:12] : i[7:4];
			e.aluOp   = op;
			e.destSel = d;
			e.destSel2 = d;
			e.bus.pcIncr = 1'b1;
			e.srcSel  = imm ? d : i[3:0];
			if (imm) begin
				e.immediate  = {8'h00, i[7:0]};
				e.bus.immSrc = 1'b1;
			end else begin
				e.bus.regSrc = 1'b1;
			end
			if (op >= ALU_ADD && op <= ALU_ARSH) begin
				e.flagWrite = 1'b1;
				{e.writeEn1, e.bus.aluToPort1} = {2{!p2}};
				{e.writeEn2, e.bus.aluToPort2} = {2{p2}};
			end else if (op == ALU_CMP || op == ALU_CMPR) begin
				e.flagWrite = 1'b1;
			end else if (op == ALU_MOVR) begin
				e.writeEn1 = !p2;
				e.writeEn2 = p2;
				if (imm) begin
					e.bus.immToPort1 = !p2;
					e.bus.immToPort2 = p2;
				end else begin
					e.bus.regToPort1 = !p2;
					e.bus.regToPort2 = p2;
				end
			end else begin
				bad = 1'b1;
			end
		end else if (i[17:16] == 2'b00) begin
			e.aluOp   = i[7:4];
			e.destSel = d;
			e.destSel2 = d;
			e.srcSel  = i[3:0];
			e.bus.regSrc = 1'b1;
			e.bus.pcIncr = 1'b1;
			e.bus.regAddr = 1'b1;
			if (i[7:4] == MEM_MOVMR) begin
				e.memRead = 1'b1;
				{e.writeEn1, e.bus.memToPort1} = {2{!p2}};
				{e.writeEn2, e.bus.memToPort2} = {2{p2}};
			end else if (i[7:4] == MEM_MOVRM) begin
				e.memWrite = 1'b1;
				e.bus.storeData = 1'b1;
			end else begin
				bad = 1'b1;
			end
		end else if (i[17:16] != 2'b11) begin
			e.addr = {2'b00, i[13:0]};
			e.destSel = PC_REG;
			e.bus.regSrc = 1'b1;
			e.bus.immAddr = 1'b1;
			if (spec == OP_CALL) begin
				{e.memWrite, e.bus.memToPort1, e.bus.pcIncr} = 3'b111;
			end else if (spec == OP_MOVMRI) begin
				{e.memRead, e.writeEn1, e.bus.memToPort1, e.bus.pcIncr} = 4'b1111;
			end else if (spec == OP_MOVRMI) begin
				{e.memWrite, e.bus.storeData, e.bus.pcIncr} = 3'b111;
			end else if (spec == OP_RET) begin
				{e.memRead, e.bus.retPc} = 2'b11;
			end else begin
				if (spec == OP_JL) taken = f.low || f.negative;
				if (spec == OP_JLE) taken = f.low || f.negative || f.zero;
				if (spec == OP_JNE) taken = !f.zero;
				if (spec == OP_JE) taken = f.zero;
				e.bus.branchPc = taken;
				e.bus.pcIncr = !taken;
			end
		end else if (i[17:12] == INCR_OP || i[17:12] == DECR_OP) begin
			e.srcSel = d;
			e.destSel = d;
			e.destSel2 = d;
			e.bus.pcIncr = 1'b1;
			{e.writeEn1, e.bus.incDecToPort1} = {2{!p2}};
			{e.writeEn2, e.bus.incDecToPort2} = {2{p2}};
			e.bus.increment = (i[17:12] == INCR_OP);
			e.bus.decrement = (i[17:12] == DECR_OP);
		end else if (spec == OP_POP || spec == OP_PUSH || spec == OP_PUSHI) begin
			e.srcSel = SP_REG;
			e.destSel2 = SP_REG;
			{e.bus.regAddr, e.bus.storeData, e.bus.pcIncr} = 3'b111;
			if (spec != OP_PUSHI) e.destSel = i[13:10];
			if (spec == OP_POP && i[13:10] != 4'd12 && i[13:10] != 4'd13) begin
				{e.writeEn1, e.writeEn2, e.memRead} = 3'b111;
				{e.bus.regSrc, e.bus.incDecToPort2, e.bus.decrement} = 3'b111;
			end else if (spec != OP_POP) begin
				{e.memWrite, e.writeEn2} = 2'b11;
				{e.bus.incDecToPort2, e.bus.increment} = 2'b11;
				e.bus.immSrc = (spec == OP_PUSHI);
				e.bus.regSrc = (spec == OP_PUSH);
			end
		end else begin
			bad = 1'b1;
		end
		if (bad) begin
			e = '0;
			e.illegal = 1'b1;
		end
		return e;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Drive and check
	////////////////////////////////////////////////////////////////////////////

	task automatic compareCtrl(input ctrlWordT exp, input instT i, input string name);
		checkCount++;
		assert (ctrlValid === 1'b1 && ctrl === exp) else begin
			$display("MISMATCH at time %0t: %s inst=%h valid=%b ctrl=%h expected %h",
				$time, name, i, ctrlValid, ctrl, exp);
			errorCount++;
		end
	endtask

	task automatic sendAndCheck(input instT i, input flagsT f, input string name);
		ctrlWordT exp;

		exp = expectCtrl(i, f);
		@(posedge clk);
		instValid <= 1'b1;
		inst      <= i;
		flags     <= f;
		@(posedge clk);
		instValid <= 1'b0;
		@(negedge clk);
		// The word must not show one cycle in
		checkCount++;
		assert (ctrlValid === 1'b0) else begin
			$display("MISMATCH at time %0t: %s ctrlValid high one cycle early", $time, name);
			errorCount++;
		end
		@(posedge clk);
		@(negedge clk);
		compareCtrl(exp, i, name);
	endtask

	task automatic checkIdle(input string name);
		@(negedge clk);
		checkCount++;
		assert (ctrlValid === 1'b0 && ctrl === '0) else begin
			$display("MISMATCH at time %0t: %s idle output not clear, valid=%b ctrl=%h",
				$time, name, ctrlValid, ctrl);
			errorCount++;
		end
	endtask

	task automatic endTest(input string name);
		testCount++;
		if (errorCount == testStartErrors) begin
			$display("ok    %s", name);
		end else begin
			failedTests++;
			$display("FAIL  %s (%0d errors)", name, errorCount - testStartErrors);
		end
		testStartErrors = errorCount;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic idleTest();
		int n;

		for (n = 0; n < 3; n++) checkIdle("after reset");
		sendAndCheck(regForm(ALU_ADD, 4'd3, 4'd4), 3'b000, "idle probe");
		for (n = 0; n < 3; n++) checkIdle("between strobes");
		endTest("idle outputs");
	endtask

	task automatic aluTest();
		int          k;
		int          n;
		aluOpT       op;
		regSelT      d;
		logic [31:0] r;

		for (k = 1; k <= 14; k++) begin
			op = aluOpT'(k);
			for (n = 0; n < 3; n++) begin
				r = lcgNext();
				d = (n == 0) ? r[27:24] : ((n == 1) ? PORT2_LOW : SP_REG);
				sendAndCheck(regForm(op, d, r[19:16]), flagsT'(r[30:28]), "register ALU");
				if (k >= 2) begin
					sendAndCheck(immForm(op, d, r[23:16]), flagsT'(r[30:28]), "imm ALU");
				end
			end
		end
		// Every destination with bit 7 set to catch sign extension
		for (n = 0; n < 16; n++) begin
			d = regSelT'(n);
			r = lcgNext();
			sendAndCheck(regForm(ALU_ADD, d, r[23:20]), 3'b000, "ADD dest sweep");
			sendAndCheck(regForm(ALU_MOVR, d, r[23:20]), 3'b000, "MOVR dest sweep");
			sendAndCheck(immForm(ALU_MOVR, d, {1'b1, r[22:16]}), 3'b000, "MOVR imm sweep");
			sendAndCheck(immForm(ALU_CMP, d, 8'hff), 3'b000, "CMP imm sweep");
		end
		endTest("ALU forms");
	endtask

	task automatic memoryTest();
		int          n;
		logic [31:0] r;

		for (n = 0; n < 16; n++) begin
			r = lcgNext();
			sendAndCheck(memForm(MEM_MOVMR, regSelT'(n), r[27:24]), 3'b000, "MOVMR");
			sendAndCheck(memForm(MEM_MOVRM, regSelT'(n), r[27:24]), 3'b000, "MOVRM");
		end
		for (n = 0; n < 4; n++) begin
			r = lcgNext();
			sendAndCheck(addrForm(OP_CALL, r[31:18]), 3'b000, "CALL");
			sendAndCheck(addrForm(OP_MOVMRI, r[29:16]), 3'b000, "MOVMRI");
			sendAndCheck(addrForm(OP_MOVRMI, r[27:14]), 3'b000, "MOVRMI");
			sendAndCheck(addrForm(OP_RET, r[25:12]), 3'b111, "RET");
		end
		endTest("memory and 14-bit address");
	endtask

	task automatic jumpTest();
		int          s;
		int          fl;
		logic [31:0] r;

		for (s = 8; s <= 11; s++) begin
			for (fl = 0; fl < 8; fl++) begin
				r = lcgNext();
				sendAndCheck(addrForm(specOpT'(s), r[31:18]), flagsT'(3'(fl)), "jump");
			end
		end
		endTest("conditional jumps");
	endtask

	task automatic stackTest();
		int          n;
		logic [31:0] r;

		for (n = 0; n < 8; n++) begin
			r = lcgNext();
			sendAndCheck(stackForm(OP_PUSH, r[31:28], r[17:8]), 3'b000, "PUSH");
			sendAndCheck(stackForm(OP_PUSHI, r[27:24], r[19:10]), 3'b000, "PUSHI");
			sendAndCheck(stackForm(OP_POP, r[23:20], r[21:12]), 3'b000, "POP");
			sendAndCheck(incDecForm(INCR_OP, r[31:28], r[23:16]), 3'b000, "INCR");
			sendAndCheck(incDecForm(DECR_OP, r[27:24], r[23:16]), 3'b000, "DECR");
		end
		sendAndCheck(stackForm(OP_POP, PORT2_LOW, 10'h155), 3'b000, "POP into 12");
		sendAndCheck(stackForm(OP_POP, SP_REG, 10'h2aa), 3'b000, "POP into 13");
		sendAndCheck(incDecForm(INCR_OP, PORT2_LOW, 8'h00), 3'b000, "INCR 12");
		sendAndCheck(incDecForm(DECR_OP, SP_REG, 8'h00), 3'b000, "DECR 13");
		endTest("stack and inc/dec");
	endtask

	task automatic streamTest();
		int          c;
		instT        i;
		logic [31:0] r;

		for (c = 0; c < STREAM_LEN + 2; c++) begin
			@(posedge clk);
			if (c < STREAM_LEN) begin
				r = lcgNext();
				i = r[31:14];
				// Plant the known illegal encodings among the random ones
				if (c == 5) i = regForm(ALU_MUL, 4'd2, 4'd3);
				if (c == 11) i = regForm(ALU_FMUL, 4'd7, 4'd1);
				if (c == 17) i = 18'h3f000;
				if (c == 23) i = memForm(memOpT'(4'd3), 4'd5, 4'd6);
				expStream[c]  = expectCtrl(i, flagsT'(r[12:10]));
				streamInst[c] = i;
				instValid <= 1'b1;
				inst      <= i;
				flags     <= flagsT'(r[12:10]);
			end else begin
				instValid <= 1'b0;
			end
			@(negedge clk);
			if (c >= 2) compareCtrl(expStream[c - 2], streamInst[c - 2], "stream slot");
		end
		endTest("back-to-back stream");
	endtask

	initial begin
		rst       = 1'b1;
		instValid = 1'b0;
		inst      = '0;
		flags     = '0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;

		idleTest();
		aluTest();
		memoryTest();
		jumpTest();
		stackTest();
		streamTest();

		$display("Tests %0d, failed %0d, checks %0d, errors %0d",
			testCount, failedTests, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- flist.f
logic/isaPkg.sv
logic/ctrlPkg.sv
logic/instClassify.sv
logic/ctrlGen.sv
logic/controlUnit.sv
sim/controlUnitTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the control unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --assert -f flist.f --top-module controlUnitTb \
	--Mdir "$BUILD_DIR" -o controlUnitSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/controlUnitSim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "ALL TESTS PASSED" "$LOG"; then
	echo "Result: pass"
	exit 0
fi
echo "Result: fail"
exit 1
